//--- dv/imuldiv_model.svh
/*
  reference results for the four multiply/divide operations
*/
`ifndef IMULDIV_MODEL_SVH
`define IMULDIV_MODEL_SVH

// full 64-bit product of operands widened by sign or by zero
function automatic logic [63:0] product_word(input logic [31:0] a, input logic [31:0] b,
                                             input logic sgn);
  logic [63:0] wa;
  logic [63:0] wb;
  wa = sgn ? {{32{a[31]}}, a} : {32'h0, a};
  wb = sgn ? {{32{b[31]}}, b} : {32'h0, b};
  // low 64 bits of the wide product are right for both modes
  return wa * wb;
endfunction

// remainder above and quotient below
function automatic logic [63:0] divide_word(input logic [31:0] a, input logic [31:0] b,
                                            input logic sgn);
  logic [31:0] q;
  logic [31:0] r;
  if (b == 32'h0) begin
    // zero divisor gives an all ones quotient and the dividend as remainder
    q = '1;
    r = a;
  end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
    // signed overflow
    q = 32'h8000_0000;
    r = 32'h0;
  end else if (sgn) begin
    // truncating division where the remainder takes the dividend sign
    q = $signed(a) / $signed(b);
    r = $signed(a) % $signed(b);
  end else begin
    q = a / b;
    r = a % b;
  end
  return {r, q};
endfunction

// expected result word for one request
function automatic logic [63:0] expected_word(input muldiv_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
  case (op)
    op_mul:  return product_word(a, b, 1'b1);
    op_mulu: return product_word(a, b, 1'b0);
    op_div:  return divide_word(a, b, 1'b1);
    default: return divide_word(a, b, 1'b0);
  endcase
endfunction

`endif

//--- dv/imuldiv_tb.sv
/*
  testbench for the multiply/divide unit
  clock, reset, lfsr stimulus, in-order scoreboard and the tests
*/
`timescale 1ns/1ns

module imuldiv_tb;
  import imuldiv_pkg::*;

  `include "imuldiv_model.svh"

  localparam int ORDER_DEPTH   = 2;
  localparam int req_timeout   = 200;
  localparam int drain_timeout = 500;
  localparam int run_timeout   = 20000;

  logic           clk = 1'b0;
  logic           reset;
  muldiv_req_t    req_msg;
  logic           req_val;
  logic           req_rdy;
  muldiv_result_u resp_msg;
  logic           resp_val;
  logic           resp_rdy;

  // lfsr state starts from seed 95
  logic [31:0]    lfsr = 32'd95;

  // expected words in issue order with bit 64 set for a divider result
  logic [64:0]    sb_q [$];
  int             mul_out = 0;
  int             div_out = 0;
  logic           saw_rdy_low = 1'b0;

  string          cur_test = "none";
  int             test_errs = 0;
  int             pass_count = 0;
  int             fail_count = 0;
  logic           hung = 1'b0;

  imuldiv_top #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) u_dut (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      pass_count++;
      $display("test %s: ok", cur_test);
    end else begin
      fail_count++;
      $display("test %s: %0d errors", cur_test, test_errs);
    end
  endtask

  // hold the request until the edge that accepts it and return 1 ns later
  task automatic issue(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    int   waited;
    logic took;
    req_msg = '{op: op, a: a, b: b};
    req_val = 1'b1;
    took    = 1'b0;
    waited  = 0;
    while (!took && waited < req_timeout) begin
      @(posedge clk);
      took = req_rdy;
      waited++;
    end
    #1;
    req_val = 1'b0;
    if (!took) begin
      $display("timeout in %s: request was never accepted", cur_test);
      test_errs++;
      hung = 1'b1;
    end
  endtask

  // wait until every accepted request has its response
  task automatic drain();
    int waited;
    waited = 0;
    while (sb_q.size() != 0 && waited < drain_timeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (sb_q.size() != 0) begin
      $display("timeout in %s: responses still missing after drain", cur_test);
      test_errs++;
      hung = 1'b1;
    end
  endtask

  task automatic one_op(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    issue(op, a, b);
    drain();
  endtask

  // ---------------------------------------------------------------------
  // scoreboard and ready prediction at the rising edge
  // ---------------------------------------------------------------------

  always @(posedge clk) begin
    logic [64:0]    exp_e;
    muldiv_result_u exp_u;
    logic           exp_rdy;
    if (!reset) begin
      // ready needs room in the order queue and an idle addressed unit
      exp_rdy = (sb_q.size() < ORDER_DEPTH) &&
                (req_msg.op[op_is_div] ? (div_out == 0) : (mul_out == 0));
      check_value("req_rdy", 64'(exp_rdy), 64'(req_rdy));
      if (!req_rdy) begin
        saw_rdy_low = 1'b1;
      end
      if (resp_val && resp_rdy) begin
        if (sb_q.size() == 0) begin
          $display("error in %s: response arrived with no request outstanding", cur_test);
          test_errs++;
        end else begin
          exp_e = sb_q.pop_front();
          exp_u = exp_e[63:0];
          if (exp_e[64]) begin
            check_value("rem", exp_u.div.rem, resp_msg.div.rem);
            check_value("quo", exp_u.div.quo, resp_msg.div.quo);
            div_out--;
          end else begin
            check_value("hi", exp_u.mul.hi, resp_msg.mul.hi);
            check_value("lo", exp_u.mul.lo, resp_msg.mul.lo);
            mul_out--;
          end
        end
      end
      // an accepted request puts its expected word at the back of the queue
      if (req_val && req_rdy) begin
        sb_q.push_back({req_msg.op[op_is_div], expected_word(req_msg.op, req_msg.a, req_msg.b)});
        if (req_msg.op[op_is_div]) begin
          div_out++;
        end else begin
          mul_out++;
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------

  task automatic reset_values();
    start_test("reset_state");
    check_value("req_rdy", 64'd1, 64'(req_rdy));
    check_value("resp_val", 64'd0, 64'(resp_val));
    end_test();
  endtask

  // div_sel picks the unit and the lfsr picks signed or unsigned
  task automatic random_singles(input string name, input logic div_sel, input int n);
    logic [31:0] a;
    logic [31:0] b;
    muldiv_op_e  op;
    start_test(name);
    for (int i = 0; i < n && !hung; i++) begin
      op = muldiv_op_e'({div_sel, 1'(rand_bits(1))});
      a  = rand_bits(32);
      b  = rand_bits(32);
      // vary divisor size so quotients are not mostly zero
      if (div_sel) begin
        b = b >> rand_bits(5);
      end
      one_op(op, a, b);
    end
    end_test();
  endtask

  task automatic div_corners();
    start_test("div_corner");
    one_op(op_div, 32'd1234, 32'h0);
    one_op(op_div, 32'h8000_0001, 32'h0);
    one_op(op_divu, 32'hffff_ffff, 32'h0);
    one_op(op_div, 32'h0, 32'h0);
    one_op(op_div, 32'h8000_0000, 32'hffff_ffff);
    one_op(op_divu, 32'h8000_0000, 32'hffff_ffff);
    one_op(op_div, 32'h0, 32'hffff_fff9);
    one_op(op_divu, 32'h0, 32'd7);
    one_op(op_mul, 32'h8000_0000, 32'h8000_0000);
    one_op(op_mulu, 32'hffff_ffff, 32'hffff_ffff);
    end_test();
  endtask

  // back-to-back mixed requests with random response stalls
  task automatic mixed_stream(input int n);
    int   sent;
    int   cycles;
    logic took;
    start_test("mixed_stream");
    saw_rdy_low = 1'b0;
    sent        = 0;
    cycles      = 0;
    while ((sent < n || sb_q.size() != 0) && cycles < run_timeout) begin
      if (!req_val && sent < n) begin
        req_msg = '{op: muldiv_op_e'(rand_bits(2)), a: rand_bits(32), b: rand_bits(32)};
        req_val = 1'b1;
      end
      // ready three cycles in four
      resp_rdy = (rand_bits(2) != 2'd0);
      @(posedge clk);
      took = req_val && req_rdy;
      #1;
      if (took) begin
        sent++;
        req_val = 1'b0;
      end
      cycles++;
    end
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    if (sent < n || sb_q.size() != 0) begin
      $display("timeout in %s: stream did not complete", cur_test);
      test_errs++;
      hung = 1'b1;
    end
    if (!saw_rdy_low) begin
      $display("error in %s: req_rdy never fell under back-to-back load", cur_test);
      test_errs++;
    end
    end_test();
  endtask

  // cycles from the accepting edge to resp_val with nothing older waiting
  task automatic latency_of(input muldiv_op_e op);
    int k;
    issue(op, rand_bits(32), rand_bits(32));
    k = 0;
    while (!resp_val && k < req_timeout) begin
      @(posedge clk);
      #1;
      k++;
    end
    if (!resp_val) begin
      $display("timeout in %s: resp_val never rose", cur_test);
      test_errs++;
      hung = 1'b1;
    end else begin
      check_value("cycles", 64'd33, 64'(k));
    end
    drain();
  endtask

  task automatic unit_latency();
    start_test("latency");
    resp_rdy = 1'b1;
    drain();
    latency_of(op_mulu);
    latency_of(op_div);
    end_test();
  endtask

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_val  = 1'b0;
    req_msg  = '0;
    resp_rdy = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset    = 1'b0;
    resp_rdy = 1'b1;

    reset_values();
    if (!hung) begin
      random_singles("mul_random", 1'b0, 40);
    end
    if (!hung) begin
      random_singles("div_random", 1'b1, 40);
    end
    if (!hung) begin
      div_corners();
    end
    if (!hung) begin
      mixed_stream(60);
    end
    if (!hung) begin
      unit_latency();
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && !hung) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- source/imuldiv_pkg.sv
/*
  shared widths, operation codes, request struct and result union
  used by the multiply/divide unit and its issue/ordering block
*/
package imuldiv_pkg;

  // ---------------------------------------------------------------------
  // fixed widths
  // ---------------------------------------------------------------------

  // operand width, the packed types below depend on it
  localparam int xlen = 32;
  // iteration count of both units, one operand bit per step
  localparam int div_steps = 32;

  // ---------------------------------------------------------------------
  // operation codes
  // ---------------------------------------------------------------------

  // bit 1 picks the unit, bit 0 picks unsigned
  typedef enum logic [1:0] {
    op_mul  = 2'b00,
    op_mulu = 2'b01,
    op_div  = 2'b10,
    op_divu = 2'b11
  } muldiv_op_e;

  // position of the divider select bit inside muldiv_op_e
  localparam int op_is_div = 1;

  // request word, 66 bits
  typedef struct packed {
    muldiv_op_e      op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } muldiv_req_t;

  // ---------------------------------------------------------------------
  // result word
  // ---------------------------------------------------------------------

  // product as written by the multiplier
  typedef struct packed {
    logic [xlen-1:0] hi;
    logic [xlen-1:0] lo;
  } mul_view_t;

  // remainder above, quotient below, as written by the divider
  typedef struct packed {
    logic [xlen-1:0] rem;
    logic [xlen-1:0] quo;
  } div_view_t;

  // one 64-bit word, read by whichever unit produced it
  typedef union packed {
    mul_view_t mul;
    div_view_t div;
  } muldiv_result_u;

  // entry type of the ordering queue
  typedef enum logic {
    unit_mul = 1'b0,
    unit_div = 1'b1
  } unit_id_e;

endpackage

//--- source/imuldiv_top.sv
/*
  multiply/divide unit top level
*/
`timescale 1ns/1ns

module imuldiv_top #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_pkg::muldiv_req_t    req_msg,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_pkg::muldiv_result_u resp_msg,
  output logic                        resp_val,
  input  logic                        resp_rdy
);
  import imuldiv_pkg::*;

  // multiplier link
  logic           mul_req_val;
  logic           mul_req_rdy;
  muldiv_result_u mul_resp_msg;
  logic           mul_resp_val;
  logic           mul_resp_rdy;

  // divider link
  logic           div_req_val;
  logic           div_req_rdy;
  muldiv_result_u div_resp_msg;
  logic           div_resp_val;
  logic           div_resp_rdy;

  // ---------------------------------------------------------------------
  // steering and ordering
  // ---------------------------------------------------------------------

  muldiv_issue_order #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) u_order (
    .clk          (clk),
    .reset        (reset),
    .req_msg      (req_msg),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_msg     (resp_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .mul_resp_msg (mul_resp_msg),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_resp_msg (div_resp_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy)
  );

  // ---------------------------------------------------------------------
  // units, both see the same request word
  // ---------------------------------------------------------------------

  int_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_msg (mul_resp_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  int_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_msg (div_resp_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

endmodule

//--- source/int_div_iterative.sv
/*
  iterative restoring divider, signed and unsigned
  idle/calc/done control and the remainder-quotient datapath
*/
`timescale 1ns/1ns

module int_div_iterative (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_pkg::muldiv_req_t    req_msg,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_pkg::muldiv_result_u resp_msg,
  output logic                        resp_val,
  input  logic                        resp_rdy
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  // control state
  state_e          state;
  logic [5:0]      step_cnt;

  // datapath registers
  // rq_reg holds a 33-bit partial remainder above a 32-bit quotient
  logic [2*xlen:0] rq_reg;
  logic [xlen-1:0] dvsr_reg;
  logic            neg_quo;
  logic            neg_rem;
  logic            div_zero;

  // operand decode at accept
  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;

  // step and sign fix
  logic [2*xlen:0] rq_shift;
  logic [xlen:0]   trial;
  logic [xlen-1:0] quo_fix;
  logic [xlen-1:0] rem_fix;
  logic [xlen-1:0] quo_out;

  // handshakes
  logic            req_go;
  logic            resp_go;
  logic            fix_cycle;

  // ---------------------------------------------------------------------
  // handshake and control
  // ---------------------------------------------------------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  // once all steps are done one more calc cycle applies the signs
  assign fix_cycle = (step_cnt == 6'(div_steps));

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state    <= st_calc;
            step_cnt <= '0;
          end
        end
        st_calc: begin
          if (fix_cycle) begin
            state <= st_done;
          end else begin
            step_cnt <= step_cnt + 6'd1;
          end
        end
        st_done: begin
          // hold the result until the consumer takes it
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // operand magnitudes
  // ---------------------------------------------------------------------

  assign is_signed = (req_msg.op == op_div);
  assign a_neg     = is_signed && req_msg.a[xlen-1];
  assign b_neg     = is_signed && req_msg.b[xlen-1];
  assign a_mag     = a_neg ? -req_msg.a : req_msg.a;
  assign b_mag     = b_neg ? -req_msg.b : req_msg.b;

  // ---------------------------------------------------------------------
  // restoring step
  // ---------------------------------------------------------------------

  assign rq_shift = rq_reg << 1;
  // top bit set means the trial went negative and the step restores
  assign trial    = rq_shift[2*xlen:xlen] - {1'b0, dvsr_reg};

  // quotient sign follows the operand signs and remainder follows the dividend
  assign quo_fix = neg_quo ? -rq_reg[xlen-1:0] : rq_reg[xlen-1:0];
  assign rem_fix = neg_rem ? -rq_reg[2*xlen-1:xlen] : rq_reg[2*xlen-1:xlen];

  // zero divisor forces an all-ones quotient
  // the remainder already comes out equal to the dividend
  assign quo_out = div_zero ? '1 : quo_fix;

  always_ff @(posedge clk) begin
    if (req_go) begin
      rq_reg   <= {{(xlen+1){1'b0}}, a_mag};
      dvsr_reg <= b_mag;
      neg_quo  <= a_neg ^ b_neg;
      neg_rem  <= a_neg;
      div_zero <= (req_msg.b == '0);
    end else if (state == st_calc) begin
      if (fix_cycle) begin
        rq_reg <= {1'b0, rem_fix, quo_out};
      end else if (trial[xlen]) begin
        rq_reg <= rq_shift;
      end else begin
        rq_reg <= {trial, rq_shift[xlen-1:1], 1'b1};
      end
    end
  end

  assign resp_msg.div = div_view_t'{rem: rq_reg[2*xlen-1:xlen], quo: rq_reg[xlen-1:0]};

  // ---------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------

  // result valid from the 33rd edge after accept, sampled one edge later
  a_resp_latency: assert property (@(posedge clk) disable iff (reset)
    req_go |-> ##(div_steps + 2) resp_val);

  // the step counter stops at the fix cycle
  a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
    step_cnt <= 6'(div_steps));

endmodule

//--- source/int_mul_iterative.sv
/*
  iterative shift-add multiplier, signed and unsigned
*/
`timescale 1ns/1ns

module int_mul_iterative (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_pkg::muldiv_req_t    req_msg,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_pkg::muldiv_result_u resp_msg,
  output logic                        resp_val,
  input  logic                        resp_rdy
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e            state;
  logic [5:0]        step_cnt;

  // accumulator, multiplicand shifting left, multiplier shifting right
  logic [2*xlen-1:0] acc_reg;
  logic [2*xlen-1:0] mcand_reg;
  logic [xlen-1:0]   mplier_reg;
  logic              neg_prod;

  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;

  logic              req_go;
  logic              resp_go;
  logic              fix_cycle;

  // ---------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  // extra cycle after the last add for the sign fix
  assign fix_cycle = (step_cnt == 6'(div_steps));

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state    <= st_calc;
            step_cnt <= '0;
          end
        end
        st_calc: begin
          if (fix_cycle) begin
            state <= st_done;
          end else begin
            step_cnt <= step_cnt + 6'd1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------

  assign is_signed = (req_msg.op == op_mul);
  assign a_neg     = is_signed && req_msg.a[xlen-1];
  assign b_neg     = is_signed && req_msg.b[xlen-1];
  // most negative number keeps its bit pattern as an unsigned magnitude
  assign a_mag     = a_neg ? -req_msg.a : req_msg.a;
  assign b_mag     = b_neg ? -req_msg.b : req_msg.b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      acc_reg    <= '0;
      mcand_reg  <= {{xlen{1'b0}}, a_mag};
      mplier_reg <= b_mag;
      neg_prod   <= a_neg ^ b_neg;
    end else if (state == st_calc) begin
      if (fix_cycle) begin
        if (neg_prod) begin
          acc_reg <= -acc_reg;
        end
      end else begin
        // add when the current multiplier bit is set
        if (mplier_reg[0]) begin
          acc_reg <= acc_reg + mcand_reg;
        end
        mcand_reg  <= mcand_reg << 1;
        mplier_reg <= mplier_reg >> 1;
      end
    end
  end

  assign resp_msg.mul = mul_view_t'{hi: acc_reg[2*xlen-1:xlen], lo: acc_reg[xlen-1:0]};

  // a stalled product stays valid and unchanged
  a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)));

endmodule

//--- source/muldiv_issue_order.sv
/*
  request steering to the multiplier or divider
  and an ordering queue that returns results in issue order
*/
`timescale 1ns/1ns

module muldiv_issue_order #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  // outside request
  input  imuldiv_pkg::muldiv_req_t    req_msg,
  input  logic                        req_val,
  output logic                        req_rdy,
  // outside response
  output imuldiv_pkg::muldiv_result_u resp_msg,
  output logic                        resp_val,
  input  logic                        resp_rdy,
  // multiplier link
  output logic                        mul_req_val,
  input  logic                        mul_req_rdy,
  input  imuldiv_pkg::muldiv_result_u mul_resp_msg,
  input  logic                        mul_resp_val,
  output logic                        mul_resp_rdy,
  // divider link
  output logic                        div_req_val,
  input  logic                        div_req_rdy,
  input  imuldiv_pkg::muldiv_result_u div_resp_msg,
  input  logic                        div_resp_val,
  output logic                        div_resp_rdy
);
  import imuldiv_pkg::*;

  localparam int ptr_w = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int cnt_w = $clog2(ORDER_DEPTH + 1);

  // unit ids in issue order
  unit_id_e         order_q [ORDER_DEPTH];
  logic [ptr_w-1:0] head_ptr;
  logic [ptr_w-1:0] tail_ptr;
  logic [cnt_w-1:0] q_count;

  logic             q_full;
  logic             q_empty;
  logic             req_is_div;
  unit_id_e         head_unit;
  logic             push;
  logic             pop;

  // circular pointer advance for any depth
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(ORDER_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ---------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------

  assign q_full     = (q_count == cnt_w'(ORDER_DEPTH));
  assign q_empty    = (q_count == '0);
  assign req_is_div = req_msg.op[op_is_div];

  // a unit only sees valid when there is room to record the order
  assign mul_req_val = req_val && !req_is_div && !q_full;
  assign div_req_val = req_val && req_is_div && !q_full;
  assign req_rdy     = !q_full && (req_is_div ? div_req_rdy : mul_req_rdy);

  assign push = req_val && req_rdy;

  // ---------------------------------------------------------------------
  // response side
  // ---------------------------------------------------------------------

  assign head_unit = order_q[head_ptr];

  // only the unit at the head may hand over its result
  assign resp_val = !q_empty &&
                    ((head_unit == unit_div) ? div_resp_val : mul_resp_val);
  assign resp_msg = (head_unit == unit_div) ? div_resp_msg : mul_resp_msg;

  assign mul_resp_rdy = resp_rdy && !q_empty && (head_unit == unit_mul);
  assign div_resp_rdy = resp_rdy && !q_empty && (head_unit == unit_div);

  assign pop = resp_val && resp_rdy;

  // ---------------------------------------------------------------------
  // ordering queue
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[tail_ptr] <= req_is_div ? unit_div : unit_mul;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      q_count  <= '0;
    end else begin
      if (push) begin
        tail_ptr <= ptr_next(tail_ptr);
      end
      if (pop) begin
        head_ptr <= ptr_next(head_ptr);
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        q_count <= q_count + 1'b1;
      end else if (pop && !push) begin
        q_count <= q_count - 1'b1;
      end
    end
  end

  // the count never grows past the queue depth
  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    q_count <= cnt_w'(ORDER_DEPTH));

  // every queue entry belongs to a unit that is busy with it
  a_count_in_flight: assert property (@(posedge clk) disable iff (reset)
    q_count == cnt_w'(!mul_req_rdy) + cnt_w'(!div_req_rdy));

endmodule

//--- src.f
+incdir+dv
source/imuldiv_pkg.sv
source/int_div_iterative.sv
source/int_mul_iterative.sv
source/muldiv_issue_order.sv
source/imuldiv_top.sv
dv/imuldiv_tb.sv
